// ==== blitter.f ====
+incdir+design
design/blitter_pkg.sv
design/blit_cfg_if.sv
design/blit_word_if.sv
design/blit_bus_if.sv
design/blit_regs.sv
design/blit_sequencer.sv
design/blit_datapath.sv
design/blit_bus_master.sv
design/blitter.sv
testbench/blitter_asserts.sv
testbench/tb_blitter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the blitter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_blitter \
   -f blitter.f \
   -o tb_blitter

./obj_dir/tb_blitter

// ==== testbench/tb_blitter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module tb_blitter import blitter_pkg::*; ();

   // words per run: copy, xor, two halftone runs, skew, short run
   localparam int RUN_WORDS   = 12 + 6 + 8 + 8 + 6 + 2;
   // register traffic, reset and fills go into the margin
   localparam int CYCLE_LIMIT = RUN_WORDS * 6 + 1500;

   logic        clk = 1'b0;
   logic        reset;
   logic        sel;
   logic [4:0]  addr;
   logic [15:0] din;
   wire  [15:0] dout;
   logic        rw;
   wire  [23:1] bm_addr;
   wire         bm_read;
   wire         bm_write;
   wire  [15:0] bm_data_out;
   logic [15:0] bm_data_in = '0;
   wire         irq;

   integer      seed = 39679;
   int          cycles = 0;
   int          reads = 0;
   logic        do_fill;
   logic [15:0] fill_salt;
   logic [15:0] mem [4096];

   // blit setup, shared by the run task and the model
   logic [15:0] sxinc, syinc, dxinc, dyinc;
   logic [23:0] saddr, daddr;
   logic [15:0] em1, em2, em3;
   int          xcount, ycount;
   hop_t        hop;
   blt_op_t     op;
   logic [3:0]  skew, line0;
   logic [15:0] ht_pat [16];
   logic [15:0] exp_mem [4096];
   int          exp_reads;

   blitter i_blitter (
      .clk         (clk),
      .reset       (reset),
      .sel         (sel),
      .addr        (addr),
      .din         (din),
      .dout        (dout),
      .rw          (rw),
      .bm_addr     (bm_addr),
      .bm_read     (bm_read),
      .bm_write    (bm_write),
      .bm_data_out (bm_data_out),
      .bm_data_in  (bm_data_in),
      .irq         (irq)
   );

   always #20 clk = ~clk;

   // ------------------------------
   // helpers
   // fill pattern mixes every address bit with a per test salt
   function automatic logic [15:0] fill_word(input int i, input logic [15:0] salt);
      return 16'(i * 40503) ^ salt ^ {i[3:0], i[11:0]};
   endfunction

   // signed byte increment widened to a 24 bit byte address step
   function automatic logic [23:0] byte_step(input logic [15:0] inc);
      return {{8{inc[15]}}, inc[15:1], 1'b0};
   endfunction

   // expected readback of a written value
   function automatic logic [15:0] readback_of(input logic [4:0] a, input logic [15:0] v);
      case (a)
         `BLT_REG_SRC_XINC, `BLT_REG_SRC_YINC, `BLT_REG_DST_XINC, `BLT_REG_DST_YINC,
         `BLT_REG_SRC_ADDR_LO, `BLT_REG_DST_ADDR_LO: return v & 16'hfffe;
         `BLT_REG_SRC_ADDR_HI, `BLT_REG_DST_ADDR_HI: return {8'h00, v[7:0]};
         `BLT_REG_HOP_OP: return {6'b0, v[9:8], 4'b0, v[3:0]};
         `BLT_REG_CTRL: return {4'b0, v[11:8], 4'b0, v[3:0]};
         default: return v;
      endcase
   endfunction

   task automatic check_equal(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      assert (act === exp) else begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   // CPU bus, one cycle per access
   task automatic cpu_write(input logic [4:0] a, input logic [15:0] d);
      sel  = 1'b1;
      rw   = 1'b0;
      addr = a;
      din  = d;
      @(negedge clk);
      sel = 1'b0;
      rw  = 1'b1;
   endtask

   task automatic cpu_read(input logic [4:0] a, output logic [15:0] d);
      sel  = 1'b1;
      rw   = 1'b1;
      addr = a;
      @(negedge clk);
      d   = dout;
      sel = 1'b0;
   endtask

   // held over two falling edges so one fill lands for sure
   task automatic fill_memory();
      fill_salt = 16'($random(seed));
      do_fill   = 1'b1;
      repeat (2) @(negedge clk);
      do_fill = 1'b0;
   endtask

   task automatic set_defaults();
      sxinc = 16'd2;
      dxinc = 16'd2;
      syinc = 16'd2;
      dyinc = 16'd2;
      em1   = 16'hffff;
      em2   = 16'hffff;
      em3   = 16'hffff;
      hop   = hop_source;
      op    = op_src;
      skew  = 4'd0;
      line0 = 4'd0;
   endtask

   // ------------------------------
   // memory model, data follows the read strobe by one cycle
   always @(negedge clk) begin
      if (do_fill) begin
         for (int i = 0; i < 4096; i++)
            mem[i] <= fill_word(i, fill_salt);
      end
      if (bm_read) begin
         bm_data_in <= mem[bm_addr[12:1]];
         reads      <= reads + 1;
      end
      if (bm_write)
         mem[bm_addr[12:1]] <= bm_data_out;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("** FAIL **");
         $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
         $fatal(1);
      end
   end

   // ------------------------------
   // reference model on a copy of memory
   // op bit {~s,~d} gives the result bit, so the op table needs no case list
   task automatic model_blit();
      logic [31:0] sbuf;
      logic [23:0] sa, da;
      logic [15:0] s, d, r, m, ht;
      logic [3:0]  ln, ov;
      logic [1:0]  hv;
      logic        nsrc, ndst, last;
      sbuf      = '0;
      sa        = saddr;
      da        = daddr;
      ln        = line0;
      ov        = op;
      hv        = hop;
      exp_reads = 0;
      for (int i = 0; i < 4096; i++)
         exp_mem[i] = mem[i];
      for (int y = 0; y < ycount; y++) begin
         for (int x = 0; x < xcount; x++) begin
            last = (x == xcount - 1);
            m    = (x == 0) ? em1 : (last ? em3 : em2);
            // source only if the halftone stage and the op both look at it
            nsrc = hv[1] && (ov[1:0] != ov[3:2]);
            ndst = (m != 16'hffff) || ({ov[2], ov[0]} != {ov[3], ov[1]});
            if (nsrc) begin
               if (sxinc[15])
                  sbuf = {exp_mem[sa[12:1]], sbuf[31:16]};
               else
                  sbuf = {sbuf[15:0], exp_mem[sa[12:1]]};
               sa        = sa + byte_step(last ? syinc : sxinc);
               exp_reads = exp_reads + 1;
            end
            d = exp_mem[da[12:1]];
            if (ndst)
               exp_reads = exp_reads + 1;
            s = sbuf[skew +: 16];
            case (hv)
               2'd0:    ht = 16'hffff;
               2'd1:    ht = ht_pat[ln];
               2'd2:    ht = s;
               default: ht = ht_pat[ln] & s;
            endcase
            for (int b = 0; b < 16; b++)
               r[b] = ov[{~ht[b], ~d[b]}];
            exp_mem[da[12:1]] = (r & m) | (d & ~m);
            da = da + byte_step(last ? dyinc : dxinc);
         end
         ln = dyinc[15] ? ln - 4'd1 : ln + 4'd1;
      end
   endtask

   // program, start, wait for irq to drop, compare reads and all of memory
   task automatic run_blit(input string name);
      int reads0;
      cpu_write(`BLT_REG_SRC_XINC, sxinc);
      cpu_write(`BLT_REG_SRC_YINC, syinc);
      cpu_write(`BLT_REG_SRC_ADDR_HI, {8'h00, saddr[23:16]});
      cpu_write(`BLT_REG_SRC_ADDR_LO, saddr[15:0]);
      cpu_write(`BLT_REG_ENDMASK1, em1);
      cpu_write(`BLT_REG_ENDMASK2, em2);
      cpu_write(`BLT_REG_ENDMASK3, em3);
      cpu_write(`BLT_REG_DST_XINC, dxinc);
      cpu_write(`BLT_REG_DST_YINC, dyinc);
      cpu_write(`BLT_REG_DST_ADDR_HI, {8'h00, daddr[23:16]});
      cpu_write(`BLT_REG_DST_ADDR_LO, daddr[15:0]);
      cpu_write(`BLT_REG_XCOUNT, 16'(xcount));
      cpu_write(`BLT_REG_YCOUNT, 16'(ycount));
      cpu_write(`BLT_REG_HOP_OP, {6'b0, hop, 4'b0, op});
      model_blit();
      reads0 = reads;
      cpu_write(`BLT_REG_CTRL, {1'b1, 3'b0, line0, 4'b0, skew});
      check_equal({name, " irq rise"}, 16'd1, {15'd0, irq});
      while (irq)
         @(negedge clk);
      check_equal({name, " reads"}, 16'(exp_reads), 16'(reads - reads0));
      for (int i = 0; i < 4096; i++)
         check_equal($sformatf("%s word %03h", name, i), exp_mem[i], mem[i]);
   endtask

   // ------------------------------
   initial begin
      logic [15:0] v;
      logic [15:0] got;
      reset   = 1'b1;
      sel     = 1'b0;
      rw      = 1'b1;
      addr    = '0;
      din     = '0;
      do_fill = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // register readback, CTRL written without the start bit
      for (int a = 0; a <= 30; a++) begin
         v = 16'($random(seed));
         if (a == 30)
            v[15] = 1'b0;
         cpu_write(a[4:0], v);
         cpu_read(a[4:0], got);
         check_equal($sformatf("readback %02h", a), readback_of(a[4:0], v), got);
      end

      // plain copy, source rows 8 words apart, destination rows 16
      set_defaults();
      xcount = 4;
      ycount = 3;
      saddr  = 24'h000200;
      syinc  = 16'd10;
      daddr  = 24'h000800;
      dyinc  = 16'd26;
      fill_memory();
      run_blit("copy");

      // xor with partial edge masks
      set_defaults();
      op     = op_xor;
      em1    = 16'h0fff;
      em3    = 16'hff00;
      xcount = 3;
      ycount = 2;
      saddr  = 24'h000200;
      syinc  = 16'd12;
      daddr  = 24'h000900;
      dyinc  = 16'd28;
      fill_memory();
      run_blit("xor masked");

      // halftone only, line wraps upward then steps down
      for (int i = 0; i < 16; i++) begin
         ht_pat[i] = 16'($random(seed));
         cpu_write(i[4:0], ht_pat[i]);
      end
      set_defaults();
      hop    = hop_halftone;
      xcount = 2;
      ycount = 4;
      line0  = 4'd14;
      daddr  = 24'h000a00;
      dyinc  = 16'd30;
      fill_memory();
      run_blit("halftone up");
      line0 = 4'd1;
      daddr = 24'h000c00;
      dyinc = 16'hffde;
      fill_memory();
      run_blit("halftone down");

      // skewed source window
      set_defaults();
      skew   = 4'd5;
      xcount = 3;
      ycount = 2;
      saddr  = 24'h000300;
      syinc  = 16'd12;
      daddr  = 24'h000e00;
      dyinc  = 16'd28;
      fill_memory();
      run_blit("skew");

      // start with no rows must not raise irq
      cpu_write(`BLT_REG_YCOUNT, 16'd0);
      cpu_write(`BLT_REG_CTRL, 16'h8000);
      repeat (8) begin
         check_equal("zero rows irq", 16'd0, {15'd0, irq});
         @(negedge clk);
      end
      set_defaults();
      hop    = hop_ones;
      op     = op_one;
      xcount = 2;
      ycount = 1;
      daddr  = 24'h001000;
      fill_memory();
      run_blit("short run");
      cpu_read(`BLT_REG_CTRL, got);
      check_equal("ctrl busy bit", 16'd0, got & 16'h8000);

      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/blitter_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module blitter_asserts (
   input wire clk,
   input wire reset,
   input wire bm_read,
   input wire bm_write,
   input wire irq
);

   // set once the first run has begun
   logic irq_seen;

   always @(posedge clk) begin
      if (reset)
         irq_seen <= 1'b0;
      else if (irq)
         irq_seen <= 1'b1;
   end

   // ------------------------------
   // memory strobes
   strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(bm_read && bm_write))
      else $error("bm_read and bm_write high in the same cycle");

   strobe_needs_irq: assert property (@(posedge clk) disable iff (reset)
      !irq |-> (!bm_read && !bm_write))
      else $error("memory strobe while irq is low");

   // outputs come out of reset quiet
   reset_clears: assert property (@(posedge clk)
      reset |=> (!bm_read && !bm_write && !irq))
      else $error("strobe or irq high after reset");

   quiet_before_irq: assert property (@(posedge clk) disable iff (reset)
      !irq_seen |-> (!bm_read && !bm_write))
      else $error("memory strobe before the first run");

endmodule

bind blitter blitter_asserts i_blitter_asserts (
   .clk      (clk),
   .reset    (reset),
   .bm_read  (bm_read),
   .bm_write (bm_write),
   .irq      (irq)
);

`default_nettype wire

// ==== design/blitter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module blitter (
   input  wire                 clk,
   input  wire                 reset,

   // CPU register port
   input  wire                 sel,
   input  wire [4:0]           addr,
   input  wire [`BLT_DW-1:0]   din,
   output wire [`BLT_DW-1:0]   dout,
   input  wire                 rw,

   // memory port
   output wire [`BLT_AW:1]     bm_addr,
   output wire                 bm_read,
   output wire                 bm_write,
   output wire [`BLT_DW-1:0]   bm_data_out,
   input  wire [`BLT_DW-1:0]   bm_data_in,

   output wire                 irq
);

   blit_cfg_if  cfg_if ();
   blit_word_if word_if ();
   blit_bus_if  bus_if ();

   // interrupt line is the busy flag
   assign irq = cfg_if.busy;

   // ------------------------------
   blit_regs i_regs (
      .clk   (clk),
      .reset (reset),
      .sel   (sel),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .rw    (rw),
      .cfg   (cfg_if.regs)
   );

   blit_sequencer i_sequencer (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg_if.engine),
      .word  (word_if.seq),
      .bus   (bus_if.seq)
   );

   blit_datapath i_datapath (
      .clk   (clk),
      .reset (reset),
      .cfg   (cfg_if.dpath),
      .word  (word_if.dpath),
      .bus   (bus_if.dpath)
   );

   blit_bus_master i_bus_master (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus_if.master),
      .bm_addr     (bm_addr),
      .bm_read     (bm_read),
      .bm_write    (bm_write),
      .bm_data_out (bm_data_out),
      .bm_data_in  (bm_data_in)
   );

endmodule

`default_nettype wire

// ==== design/blit_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module blit_bus_master (
   input  wire                clk,
   input  wire                reset,
   blit_bus_if.master         bus,
   output logic [`BLT_AW:1]   bm_addr,
   output logic               bm_read,
   output logic               bm_write,
   output logic [`BLT_DW-1:0] bm_data_out,
   input  wire [`BLT_DW-1:0]  bm_data_in
);

   logic               done_q;

   // strobes one cycle after the request, completion one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         bm_read  <= 1'b0;
         bm_write <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         bm_read  <= bus.read_req;
         bm_write <= bus.write_req;
         done_q   <= bm_read || bm_write;
      end
   end

   // address and write data held for the strobe cycle
   always_ff @(posedge clk) begin
      if (bus.read_req || bus.write_req)
         bm_addr <= bus.addr;
      if (bus.write_req)
         bm_data_out <= bus.wdata;
   end

   assign bus.done  = done_q;
   // memory data passes through in the done cycle of a read
   assign bus.rdata = bm_data_in;

endmodule

`default_nettype wire

// ==== design/blit_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module blit_datapath import blitter_pkg::*; (
   input  wire         clk,
   input  wire         reset,
   blit_cfg_if.dpath   cfg,
   blit_word_if.dpath  word,
   blit_bus_if.dpath   bus
);

   logic [31:0]        src_buf;
   logic [`BLT_DW-1:0] dest;
   logic [`BLT_DW-1:0] src_skewed;
   logic [`BLT_DW-1:0] src_ht;
   logic [`BLT_DW-1:0] result;
   logic [`BLT_DW-1:0] mask;
   logic               hop_uses_src;
   logic               op_uses_src;
   logic               op_uses_dest;

   // ------------------------------
   // source buffer, two words wide for the skew window
   always_ff @(posedge clk) begin
      if (reset || word.clear_src)
         src_buf <= '0;
      else if (word.load_src) begin
         if (word.src_left)
            src_buf <= {src_buf[15:0], bus.rdata};
         else
            src_buf <= {bus.rdata, src_buf[31:16]};
      end
   end

   always_ff @(posedge clk) begin
      if (word.load_dest)
         dest <= bus.rdata;
   end

   // ------------------------------
   // skew, halftone, logic op
   assign src_skewed   = src_buf[cfg.skew +: `BLT_DW];
   assign cfg.ht_index = word.line;

   always_comb begin
      case (cfg.hop)
         hop_ones:     src_ht = `BLT_MASK_ALL;
         hop_halftone: src_ht = cfg.ht_word;
         hop_source:   src_ht = src_skewed;
         default:      src_ht = cfg.ht_word & src_skewed;
      endcase
   end

   always_comb begin
      case (cfg.op)
         op_zero:            result = '0;
         op_and:             result = src_ht & dest;
         op_src_and_not_dst: result = src_ht & ~dest;
         op_src:             result = src_ht;
         op_not_src_and_dst: result = ~src_ht & dest;
         op_dst:             result = dest;
         op_xor:             result = src_ht ^ dest;
         op_or:              result = src_ht | dest;
         op_nor:             result = ~(src_ht | dest);
         op_xnor:            result = ~(src_ht ^ dest);
         op_not_dst:         result = ~dest;
         op_src_or_not_dst:  result = src_ht | ~dest;
         op_not_src:         result = ~src_ht;
         op_not_src_or_dst:  result = ~src_ht | dest;
         op_nand:            result = ~(src_ht & dest);
         default:            result = `BLT_MASK_ALL;
      endcase
   end

   // ------------------------------
   // end mask, first wins when a row is a single word
   assign mask = word.first ? cfg.endmask1 :
                 word.last  ? cfg.endmask3 : cfg.endmask2;

   assign bus.wdata = (result & mask) | (dest & ~mask);

   // fetch decisions
   assign hop_uses_src = (cfg.hop == hop_source) || (cfg.hop == hop_and);
   assign op_uses_src  = !(cfg.op inside {op_zero, op_dst, op_not_dst, op_one});
   assign op_uses_dest = !(cfg.op inside {op_zero, op_src, op_not_src, op_one});

   assign word.need_src  = hop_uses_src && op_uses_src;
   // partial mask keeps old destination bits
   assign word.need_dest = (mask != `BLT_MASK_ALL) || op_uses_dest;

endmodule

`default_nettype wire

// ==== design/blit_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module blit_sequencer import blitter_pkg::*; (
   input  wire          clk,
   input  wire          reset,
   blit_cfg_if.engine   cfg,
   blit_word_if.seq     word,
   blit_bus_if.seq      bus
);

   seq_state_t       state;
   // set from start until the last write completes
   logic             running;
   logic [`BLT_AW:1] src_addr;
   logic [`BLT_AW:1] dst_addr;
   logic [15:0]      xcnt;
   logic [15:0]      ycnt;
   logic [3:0]       line;
   logic             row_end;

   // signed increments widened to address width
   logic [`BLT_AW:1] src_xstep, src_ystep, dst_xstep, dst_ystep;

   assign src_xstep = {{(`BLT_AW-15){cfg.src_xinc[15]}}, cfg.src_xinc};
   assign src_ystep = {{(`BLT_AW-15){cfg.src_yinc[15]}}, cfg.src_yinc};
   assign dst_xstep = {{(`BLT_AW-15){cfg.dst_xinc[15]}}, cfg.dst_xinc};
   assign dst_ystep = {{(`BLT_AW-15){cfg.dst_yinc[15]}}, cfg.dst_yinc};

   assign row_end = (xcnt == 16'd1);

   // ------------------------------
   // word position to the data path
   // the register x count is the reload value
   assign word.first    = (xcnt == cfg.xcount);
   assign word.last     = row_end;
   assign word.line     = line;
   assign word.src_left = !cfg.src_xinc[15];
   // read data is valid in the done cycle
   assign word.load_src  = (state == st_src_read) && bus.done;
   assign word.load_dest = (state == st_dst_read) && bus.done;

   // address of the access in flight, sampled by the bus master with the request
   assign bus.addr = (state == st_src_read) ? src_addr : dst_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= st_idle;
         running        <= 1'b0;
         bus.read_req   <= 1'b0;
         bus.write_req  <= 1'b0;
         word.clear_src <= 1'b0;
         cfg.done_pulse <= 1'b0;
      end else begin
         // strobes default low
         bus.read_req   <= 1'b0;
         bus.write_req  <= 1'b0;
         word.clear_src <= 1'b0;
         cfg.done_pulse <= 1'b0;

         case (state)
            st_idle: begin
               if (cfg.start) begin
                  // take over the programmed setup
                  src_addr       <= cfg.src_addr;
                  dst_addr       <= cfg.dst_addr;
                  xcnt           <= cfg.xcount;
                  ycnt           <= cfg.ycount;
                  line           <= cfg.start_line;
                  running        <= 1'b1;
                  word.clear_src <= 1'b1;
               end else if (running) begin
                  // word start, pick the first access from the current column
                  if (word.need_src) begin
                     state        <= st_src_read;
                     bus.read_req <= 1'b1;
                  end else if (word.need_dest) begin
                     state        <= st_dst_read;
                     bus.read_req <= 1'b1;
                  end else begin
                     state         <= st_write;
                     bus.write_req <= 1'b1;
                  end
               end
            end

            st_src_read: begin
               if (bus.done) begin
                  // source steps on every word it is read
                  if (row_end)
                     src_addr <= src_addr + src_ystep;
                  else
                     src_addr <= src_addr + src_xstep;
                  if (word.need_dest) begin
                     state        <= st_dst_read;
                     bus.read_req <= 1'b1;
                  end else begin
                     state         <= st_write;
                     bus.write_req <= 1'b1;
                  end
               end
            end

            st_dst_read: begin
               if (bus.done) begin
                  state         <= st_write;
                  bus.write_req <= 1'b1;
               end
            end

            st_write: begin
               if (bus.done) begin
                  state <= st_idle;
                  if (!row_end) begin
                     dst_addr <= dst_addr + dst_xstep;
                     xcnt     <= xcnt - 16'd1;
                  end else begin
                     // row end, y step and halftone line follows the y direction
                     dst_addr <= dst_addr + dst_ystep;
                     xcnt     <= cfg.xcount;
                     ycnt     <= ycnt - 16'd1;
                     if (cfg.dst_yinc[15])
                        line <= line - 4'd1;
                     else
                        line <= line + 4'd1;
                     if (ycnt == 16'd1) begin
                        running        <= 1'b0;
                        cfg.done_pulse <= 1'b1;
                     end
                  end
               end
            end

            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/blit_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

module blit_regs import blitter_pkg::*; (
   input  wire               clk,
   input  wire               reset,
   input  wire               sel,
   input  wire [4:0]         addr,
   input  wire [`BLT_DW-1:0] din,
   output logic [`BLT_DW-1:0] dout,
   input  wire               rw,
   blit_cfg_if.regs          cfg
);

   logic [`BLT_DW-1:0] ht_ram [`BLT_HT_LINES];
   // y count as programmed, engine runs on its own working copy
   logic [15:0]        ycount;
   logic               wr;
   logic               start_ok;

   assign wr       = sel && !rw;
   // start needs rows to do and an idle engine
   assign start_ok = wr && (addr == `BLT_REG_CTRL) && din[15] &&
                     (ycount != 16'd0) && !cfg.busy;

   assign cfg.ycount  = ycount;
   assign cfg.ht_word = ht_ram[cfg.ht_index];

   // ------------------------------
   // CPU writes, always full words
   always_ff @(posedge clk) begin
      if (wr) begin
         if (addr <= `BLT_REG_HT_END)
            ht_ram[addr[3:0]] <= din;
         case (addr)
            `BLT_REG_SRC_XINC:    cfg.src_xinc <= din[15:1];
            `BLT_REG_SRC_YINC:    cfg.src_yinc <= din[15:1];
            `BLT_REG_SRC_ADDR_HI: cfg.src_addr[23:16] <= din[7:0];
            `BLT_REG_SRC_ADDR_LO: cfg.src_addr[15:1] <= din[15:1];
            `BLT_REG_ENDMASK1:    cfg.endmask1 <= din;
            `BLT_REG_ENDMASK2:    cfg.endmask2 <= din;
            `BLT_REG_ENDMASK3:    cfg.endmask3 <= din;
            `BLT_REG_DST_XINC:    cfg.dst_xinc <= din[15:1];
            `BLT_REG_DST_YINC:    cfg.dst_yinc <= din[15:1];
            `BLT_REG_DST_ADDR_HI: cfg.dst_addr[23:16] <= din[7:0];
            `BLT_REG_DST_ADDR_LO: cfg.dst_addr[15:1] <= din[15:1];
            `BLT_REG_XCOUNT:      cfg.xcount <= din;
            `BLT_REG_YCOUNT:      ycount <= din;
            `BLT_REG_HOP_OP: begin
               cfg.hop <= hop_t'(din[9:8]);
               cfg.op  <= blt_op_t'(din[3:0]);
            end
            `BLT_REG_CTRL: begin
               cfg.start_line <= din[11:8];
               cfg.skew       <= din[3:0];
            end
            default: ;
         endcase
      end
   end

   // ------------------------------
   // busy and start control
   // start follows the accepted write by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg.busy  <= 1'b0;
         cfg.start <= 1'b0;
      end else begin
         cfg.start <= start_ok;
         if (start_ok)
            cfg.busy <= 1'b1;
         else if (cfg.done_pulse)
            cfg.busy <= 1'b0;
      end
   end

   // ------------------------------
   // readback, low address bits and increment bit 0 read as zero
   always_comb begin
      dout = '0;
      if (sel && rw) begin
         case (addr)
            `BLT_REG_SRC_XINC:    dout = {cfg.src_xinc, 1'b0};
            `BLT_REG_SRC_YINC:    dout = {cfg.src_yinc, 1'b0};
            `BLT_REG_SRC_ADDR_HI: dout = {8'h00, cfg.src_addr[23:16]};
            `BLT_REG_SRC_ADDR_LO: dout = {cfg.src_addr[15:1], 1'b0};
            `BLT_REG_ENDMASK1:    dout = cfg.endmask1;
            `BLT_REG_ENDMASK2:    dout = cfg.endmask2;
            `BLT_REG_ENDMASK3:    dout = cfg.endmask3;
            `BLT_REG_DST_XINC:    dout = {cfg.dst_xinc, 1'b0};
            `BLT_REG_DST_YINC:    dout = {cfg.dst_yinc, 1'b0};
            `BLT_REG_DST_ADDR_HI: dout = {8'h00, cfg.dst_addr[23:16]};
            `BLT_REG_DST_ADDR_LO: dout = {cfg.dst_addr[15:1], 1'b0};
            `BLT_REG_XCOUNT:      dout = cfg.xcount;
            `BLT_REG_YCOUNT:      dout = ycount;
            `BLT_REG_HOP_OP:      dout = {6'b0, cfg.hop, 4'b0, cfg.op};
            `BLT_REG_CTRL:        dout = {cfg.busy, 3'b0, cfg.start_line, 4'b0, cfg.skew};
            default: begin
               // 0x1f reads zero
               if (addr <= `BLT_REG_HT_END)
                  dout = ht_ram[addr[3:0]];
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/blit_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

interface blit_bus_if ();

   // one access at a time, requests are single cycle pulses
   logic [`BLT_AW:1]   addr;
   logic               read_req;
   logic               write_req;
   logic [`BLT_DW-1:0] wdata;
   // completion, rdata valid alongside done of a read
   logic [`BLT_DW-1:0] rdata;
   logic               done;

   modport seq    (output addr, read_req, write_req, input done);
   modport dpath  (output wdata, input rdata);
   modport master (
      input  addr, read_req, write_req, wdata,
      output rdata, done
   );

endinterface

`default_nettype wire

// ==== design/blit_word_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface blit_word_if ();

   // column position and halftone line of the current word
   logic       first;
   logic       last;
   logic [3:0] line;
   // one cycle strobes into the data path
   logic       load_src;
   logic       load_dest;
   logic       clear_src;
   // source walks left to right
   logic       src_left;
   // fetch decisions back from the data path
   logic       need_src;
   logic       need_dest;

   modport seq (
      output first, last, line, load_src, load_dest, clear_src, src_left,
      input  need_src, need_dest
   );
   modport dpath (
      input  first, last, line, load_src, load_dest, clear_src, src_left,
      output need_src, need_dest
   );

endinterface

`default_nettype wire

// ==== design/blit_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blitter_defs.svh"

interface blit_cfg_if import blitter_pkg::*; ();

   // programmed configuration, held by the register file
   logic [15:1]       src_xinc, src_yinc;
   logic [15:1]       dst_xinc, dst_yinc;
   logic [`BLT_AW:1]  src_addr, dst_addr;
   logic [`BLT_DW-1:0] endmask1, endmask2, endmask3;
   logic [15:0]       xcount, ycount;
   hop_t              hop;
   blt_op_t           op;
   logic [3:0]        skew;
   logic [3:0]        start_line;

   // run control
   logic              start;
   logic              busy;
   logic              done_pulse;

   // halftone RAM read port, combinational
   logic [3:0]        ht_index;
   logic [`BLT_DW-1:0] ht_word;

   modport regs (
      output src_xinc, src_yinc, dst_xinc, dst_yinc, src_addr, dst_addr,
      output endmask1, endmask2, endmask3, xcount, ycount, hop, op, skew, start_line,
      output start, busy, ht_word,
      input  done_pulse, ht_index
   );
   modport engine (
      input  src_xinc, src_yinc, dst_xinc, dst_yinc, src_addr, dst_addr,
      input  xcount, ycount, start_line, start,
      output done_pulse
   );
   modport dpath (
      input  endmask1, endmask2, endmask3, hop, op, skew, ht_word,
      output ht_index
   );

endinterface

`default_nettype wire

// ==== design/blitter_pkg.sv ====
`default_nettype none

package blitter_pkg;

   // per word sequencing, idle also covers the word start decision
   typedef enum logic [1:0] {
      st_idle,
      st_src_read,
      st_dst_read,
      st_write
   } seq_state_t;

   // logic ops, encoding follows the hardware op field
   typedef enum logic [3:0] {
      op_zero,
      op_and,
      op_src_and_not_dst,
      op_src,
      op_not_src_and_dst,
      op_dst,
      op_xor,
      op_or,
      op_nor,
      op_xnor,
      op_not_dst,
      op_src_or_not_dst,
      op_not_src,
      op_not_src_or_dst,
      op_nand,
      op_one
   } blt_op_t;

   // halftone combine
   typedef enum logic [1:0] {
      hop_ones,
      hop_halftone,
      hop_source,
      hop_and
   } hop_t;

endpackage

`default_nettype wire

// ==== design/blitter_defs.svh ====
`ifndef BLITTER_DEFS_SVH
`define BLITTER_DEFS_SVH

// data word and word address widths, address runs 23 down to 1
`define BLT_DW              16
`define BLT_AW              23

// halftone pattern RAM depth and the mask that keeps every bit
`define BLT_HT_LINES        16
`define BLT_MASK_ALL        16'hffff

// ------------------------------
// register map, word offsets on the CPU bus
// halftone RAM occupies 0x00 up to BLT_REG_HT_END
`define BLT_REG_HT_END      5'h0f
`define BLT_REG_SRC_XINC    5'h10
`define BLT_REG_SRC_YINC    5'h11
`define BLT_REG_SRC_ADDR_HI 5'h12
`define BLT_REG_SRC_ADDR_LO 5'h13
`define BLT_REG_ENDMASK1    5'h14
`define BLT_REG_ENDMASK2    5'h15
`define BLT_REG_ENDMASK3    5'h16
`define BLT_REG_DST_XINC    5'h17
`define BLT_REG_DST_YINC    5'h18
`define BLT_REG_DST_ADDR_HI 5'h19
`define BLT_REG_DST_ADDR_LO 5'h1a
`define BLT_REG_XCOUNT      5'h1b
`define BLT_REG_YCOUNT      5'h1c
`define BLT_REG_HOP_OP      5'h1d
`define BLT_REG_CTRL        5'h1e

`endif
